/* list.f */
+incdir+.
ex_pkg.sv
ex_ctrl.sv
ex_logic_shift.sv
ex_arith.sv
ex_mult.sv
ex_hilo.sv
ex_result.sv
ex_top.sv
ex_checker.sv
tb_ex.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_ex
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_ex.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_ex;
    import ex_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int STALL_LIMIT  = 10;   // cycles allowed for stall_o to drop

    // one table row with stimulus then expected outputs
    typedef struct packed {
        aluop_t    op;
        alusel_t   sel;
        word_t     r1;
        word_t     r2;
        reg_addr_t wd;
        logic      wreg;
        word_t     exp_wdata;
        logic      exp_wreg;
        logic      exp_whilo;
        word_t     exp_hi;
        word_t     exp_lo;
    } row_t;

    logic      clk;
    logic      rst_n;
    aluop_t    aluop;
    alusel_t   alusel;
    word_t     reg1;
    word_t     reg2;
    reg_addr_t wd;
    logic      wreg;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     wdata_o;
    logic      whilo_o;
    word_t     hi_o;
    word_t     lo_o;
    logic      stall_o;

    row_t rows[$];

    ex_top dut0 (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .aluop_i    (aluop),
        .alusel_i   (alusel),
        .reg1_i     (reg1),
        .reg2_i     (reg2),
        .wd_i       (wd),
        .wreg_i     (wreg),
        .wd_o       (wd_o),
        .wreg_o     (wreg_o),
        .wdata_o    (wdata_o),
        .whilo_o    (whilo_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o),
        .stall_o    (stall_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // wd follows the row number
    function automatic void add_row(input aluop_t op, input alusel_t sel, input word_t r1,
                                    input word_t r2, input logic wr, input word_t exp_wdata,
                                    input logic exp_wreg, input logic exp_whilo,
                                    input word_t exp_hi, input word_t exp_lo);
        rows.push_back(row_t'{op, sel, r1, r2, reg_addr_t'(rows.size() + 1), wr,
                              exp_wdata, exp_wreg, exp_whilo, exp_hi, exp_lo});
    endfunction

    function automatic void alu_row(input aluop_t op, input alusel_t sel, input word_t r1,
                                    input word_t r2, input word_t exp_wdata,
                                    input logic exp_wreg);
        add_row(op, sel, r1, r2, 1'b1, exp_wdata, exp_wreg, 1'b0, '0, '0);
    endfunction

    function automatic void hilo_row(input aluop_t op, input word_t r1, input word_t r2,
                                     input word_t exp_hi, input word_t exp_lo);
        add_row(op, `EX_SEL_NOP, r1, r2, 1'b0, '0, 1'b0, 1'b1, exp_hi, exp_lo);
    endfunction

    function automatic logic expects_stall(input aluop_t op);
        return (op == `EX_OP_MADD) || (op == `EX_OP_MADDU) ||
               (op == `EX_OP_MSUB) || (op == `EX_OP_MSUBU);
    endfunction

    function automatic void fill_table();
        alu_row(`EX_OP_OR,    `EX_SEL_LOGIC, 32'hf0f0_0000, 32'h0000_0f0f, 32'hf0f0_0f0f, 1);
        alu_row(`EX_OP_AND,   `EX_SEL_LOGIC, 32'hff00_ff00, 32'h0f0f_0f0f, 32'h0f00_0f00, 1);
        alu_row(`EX_OP_NOR,   `EX_SEL_LOGIC, 32'hf0f0_0000, 32'h0000_0f0f, 32'h0f0f_f0f0, 1);
        alu_row(`EX_OP_XOR,   `EX_SEL_LOGIC, 32'haaaa_5555, 32'hffff_0000, 32'h5555_5555, 1);
        alu_row(`EX_OP_SLL,   `EX_SEL_SHIFT, 32'd4,         32'h0000_00ff, 32'h0000_0ff0, 1);
        alu_row(`EX_OP_SLL,   `EX_SEL_SHIFT, 32'hffff_ffe8, 32'h0000_1234, 32'h0012_3400, 1);
        alu_row(`EX_OP_SRL,   `EX_SEL_SHIFT, 32'd8,         32'h8000_0000, 32'h0080_0000, 1);
        alu_row(`EX_OP_SRA,   `EX_SEL_SHIFT, 32'd4,         32'h8000_00f0, 32'hf800_000f, 1);
        alu_row(`EX_OP_SRA,   `EX_SEL_SHIFT, 32'h0000_0fff, 32'hf000_0000, 32'hffff_ffff, 1);
        // signed overflow drops the write on add, addi and sub only
        alu_row(`EX_OP_ADD,   `EX_SEL_ARITH, 32'd5,         32'd7,         32'd12,        1);
        alu_row(`EX_OP_ADD,   `EX_SEL_ARITH, 32'h7fff_ffff, 32'd1,         32'h8000_0000, 0);
        alu_row(`EX_OP_ADDU,  `EX_SEL_ARITH, 32'h7fff_ffff, 32'd1,         32'h8000_0000, 1);
        alu_row(`EX_OP_ADDI,  `EX_SEL_ARITH, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 0);
        alu_row(`EX_OP_ADDIU, `EX_SEL_ARITH, 32'hffff_ffff, 32'h0000_0010, 32'h0000_000f, 1);
        alu_row(`EX_OP_SUB,   `EX_SEL_ARITH, 32'd10,        32'd3,         32'd7,         1);
        alu_row(`EX_OP_SUB,   `EX_SEL_ARITH, 32'h8000_0000, 32'd1,         32'h7fff_ffff, 0);
        alu_row(`EX_OP_SUBU,  `EX_SEL_ARITH, 32'h8000_0000, 32'd1,         32'h7fff_ffff, 1);
        alu_row(`EX_OP_SUB,   `EX_SEL_ARITH, 32'd3,         32'd10,        32'hffff_fff9, 1);
        add_row(`EX_OP_ADD, `EX_SEL_ARITH, 32'd1, 32'd1, 1'b0, 32'd2, 1'b0, 1'b0, '0, '0);
        alu_row(`EX_OP_SLT,   `EX_SEL_ARITH, 32'hffff_ffff, 32'd1,         32'd1,         1);
        alu_row(`EX_OP_SLTU,  `EX_SEL_ARITH, 32'hffff_ffff, 32'd1,         32'd0,         1);
        alu_row(`EX_OP_SLT,   `EX_SEL_ARITH, 32'h8000_0000, 32'h7fff_ffff, 32'd1,         1);
        alu_row(`EX_OP_SLTU,  `EX_SEL_ARITH, 32'h8000_0000, 32'h7fff_ffff, 32'd0,         1);
        alu_row(`EX_OP_CLZ,   `EX_SEL_ARITH, 32'h0000_0000, 32'd0,         32'd32,        1);
        alu_row(`EX_OP_CLZ,   `EX_SEL_ARITH, 32'hffff_ffff, 32'd0,         32'd0,         1);
        alu_row(`EX_OP_CLZ,   `EX_SEL_ARITH, 32'h0000_0001, 32'd0,         32'd31,        1);
        alu_row(`EX_OP_CLZ,   `EX_SEL_ARITH, 32'h0010_0000, 32'd0,         32'd11,        1);
        alu_row(`EX_OP_CLO,   `EX_SEL_ARITH, 32'hffff_ffff, 32'd0,         32'd32,        1);
        alu_row(`EX_OP_CLO,   `EX_SEL_ARITH, 32'h0000_0000, 32'd0,         32'd0,         1);
        alu_row(`EX_OP_CLO,   `EX_SEL_ARITH, 32'hfff0_0000, 32'd0,         32'd12,        1);
        alu_row(`EX_OP_CLO,   `EX_SEL_ARITH, 32'h8000_0000, 32'd0,         32'd1,         1);
        alu_row(`EX_OP_MUL,   `EX_SEL_MUL,   32'hffff_fffd, 32'd7,         32'hffff_ffeb, 1);
        alu_row(`EX_OP_MUL,   `EX_SEL_MUL,   32'h0001_0000, 32'h0001_0000, 32'd0,         1);
        hilo_row(`EX_OP_MULT,  32'hffff_fffe, 32'd3, 32'hffff_ffff, 32'hffff_fffa);
        alu_row(`EX_OP_MFHI,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'hffff_ffff, 1);
        alu_row(`EX_OP_MFLO,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'hffff_fffa, 1);
        hilo_row(`EX_OP_MULTU, 32'hffff_fffe, 32'd3, 32'h0000_0002, 32'hffff_fffa);
        hilo_row(`EX_OP_MULTU, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 32'h0);
        hilo_row(`EX_OP_MTHI,  32'h1234_5678, 32'd0, 32'h1234_5678, 32'h0);
        hilo_row(`EX_OP_MTLO,  32'h9abc_def0, 32'd0, 32'h1234_5678, 32'h9abc_def0);
        alu_row(`EX_OP_MFHI,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'h1234_5678, 1);
        alu_row(`EX_OP_MFLO,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'h9abc_def0, 1);
        // accumulate sequence from hi:lo of 100
        hilo_row(`EX_OP_MTHI,  32'd0,         32'd0, 32'h0, 32'h9abc_def0);
        hilo_row(`EX_OP_MTLO,  32'd100,       32'd0, 32'h0, 32'd100);
        // write request held, dropped only in the bubble
        add_row(`EX_OP_MADD, `EX_SEL_NOP, 32'hffff_fffd, 32'd5, 1'b1, '0, 1'b1,
                1'b1, 32'h0, 32'd85);
        alu_row(`EX_OP_MFLO,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'd85,        1);
        hilo_row(`EX_OP_MSUB,  32'hffff_fffd, 32'd5, 32'h0, 32'd100);
        hilo_row(`EX_OP_MSUBU, 32'hffff_ffff, 32'd2, 32'hffff_fffe, 32'h0000_0066);
        alu_row(`EX_OP_MFHI,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'hffff_fffe, 1);
        hilo_row(`EX_OP_MADDU, 32'hffff_ffff, 32'd2, 32'h0, 32'd100);
        alu_row(`EX_OP_MFHI,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'd0,         1);
        hilo_row(`EX_OP_MADD,  32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h8000_0064);
        alu_row(`EX_OP_MFLO,  `EX_SEL_MOVE,  32'd0,         32'd0,         32'h8000_0064, 1);
    endfunction

    task automatic wait_stall_low();
        int cycles;
        cycles = 0;
        while (stall_o)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > STALL_LIMIT)
            begin
                $display("stall_o stayed high for more than %0d cycles", STALL_LIMIT);
                $display("TEST FAIL");
                $fatal(1, "timeout waiting for stall_o to fall");
            end
        end
    endtask

    // starts on a falling edge and ends on the one after the result
    task automatic apply_row(input int idx, input row_t r);
        string tag;
        tag    = $sformatf("row %0d ", idx);
        aluop  = r.op;
        alusel = r.sel;
        reg1   = r.r1;
        reg2   = r.r2;
        wd     = r.wd;
        wreg   = r.wreg;
        #1;
        check_val({tag, "stall_o"}, stall_o, expects_stall(r.op));
        if (expects_stall(r.op))
        begin
            wait_stall_low();
            check_val({tag, "wreg_o in bubble"}, wreg_o, 1'b0);
            check_val({tag, "whilo_o in bubble"}, whilo_o, 1'b0);
        end
        @(negedge clk);
        check_val({tag, "wd_o"}, wd_o, r.wd);
        check_val({tag, "wreg_o"}, wreg_o, r.exp_wreg);
        check_val({tag, "wdata_o"}, wdata_o, r.exp_wdata);
        check_val({tag, "whilo_o"}, whilo_o, r.exp_whilo);
        check_val({tag, "hi_o"}, hi_o, r.exp_hi);
        check_val({tag, "lo_o"}, lo_o, r.exp_lo);
    endtask

    initial
    begin
        rst_n  = 1'b0;
        aluop  = `EX_OP_NOP;
        alusel = `EX_SEL_NOP;
        reg1   = '0;
        reg2   = '0;
        wd     = '0;
        wreg   = 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_val("wreg_o after reset", wreg_o, 1'b0);
        check_val("whilo_o after reset", whilo_o, 1'b0);
        check_val("stall_o after reset", stall_o, 1'b0);
        check_val("wdata_o after reset", wdata_o, '0);
        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(i, rows[i]);
        end
        if (dut0.u_checker.fail_cnt == 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("%0d assertion failures in the checker", dut0.u_checker.fail_cnt);
            $display("TEST FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* ex_checker.sv */
`timescale 1ns/1ps

module ex_checker (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    stall_i,
    input  logic    wreg_i,
    input  logic    whilo_i
);
    int rst_fails    = 0;
    int stall_fails  = 0;
    int bubble_fails = 0;
    int fail_cnt;

    assign fail_cnt = rst_fails + stall_fails + bubble_fails;

    // write strobes cleared by reset
    reset_clears: assert property (@(posedge clk) !rst_n_i |=> (!wreg_i && !whilo_i))
    else
    begin
        $error("write strobe high after a reset cycle");
        rst_fails++;
    end

    stall_single: assert property (@(posedge clk) disable iff (!rst_n_i) stall_i |=> !stall_i)
    else
    begin
        $error("stall_o high in two consecutive cycles");
        stall_fails++;
    end

    // first macc edge leaves a bubble
    stall_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
                                   stall_i |=> (!wreg_i && !whilo_i))
    else
    begin
        $error("write strobe high after a stall cycle");
        bubble_fails++;
    end

endmodule

bind ex_top ex_checker u_checker (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall_o),
    .wreg_i     (wreg_o),
    .whilo_i    (whilo_o)
);

/* ex_top.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ex_pkg::aluop_t      aluop_i,
    input  ex_pkg::alusel_t     alusel_i,
    input  ex_pkg::word_t       reg1_i,
    input  ex_pkg::word_t       reg2_i,
    input  ex_pkg::reg_addr_t   wd_i,
    input  logic                wreg_i,
    output ex_pkg::reg_addr_t   wd_o,
    output logic                wreg_o,
    output ex_pkg::word_t       wdata_o,
    output logic                whilo_o,
    output ex_pkg::word_t       hi_o,
    output ex_pkg::word_t       lo_o,
    output logic                stall_o
);
    import ex_pkg::*;

    logic                       mult_signed;
    logic                       prod_negate;
    logic                       sub;
    logic                       slt_signed;
    logic [`EX_HILO_SRC_W-1:0]  hilo_src;
    logic                       stash;
    logic                       whilo;
    logic                       wreg;
    logic                       ovf;

    word_t  logic_res;
    word_t  shift_res;
    word_t  arith_res;
    dword_t prod;
    word_t  hi_cur;
    word_t  lo_cur;
    word_t  hi_wr;
    word_t  lo_wr;

    ex_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .aluop_i        (aluop_i),
        .wreg_i         (wreg_i),
        .ovf_i          (ovf),
        .stall_o        (stall_o),
        .mult_signed_o  (mult_signed),
        .prod_negate_o  (prod_negate),
        .sub_o          (sub),
        .slt_signed_o   (slt_signed),
        .hilo_src_o     (hilo_src),
        .stash_o        (stash),
        .whilo_o        (whilo),
        .wreg_o         (wreg)
    );

    ex_logic_shift u_logic_shift (
        .aluop_i    (aluop_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .logic_o    (logic_res),
        .shift_o    (shift_res)
    );

    ex_arith u_arith (
        .aluop_i        (aluop_i),
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .sub_i          (sub),
        .slt_signed_i   (slt_signed),
        .arith_o        (arith_res),
        .ovf_o          (ovf)
    );

    ex_mult u_mult (
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .mult_signed_i  (mult_signed),
        .prod_negate_i  (prod_negate),
        .prod_o         (prod)
    );

    ex_hilo u_hilo (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .reg1_i     (reg1_i),
        .prod_i     (prod),
        .hilo_src_i (hilo_src),
        .stash_i    (stash),
        .whilo_i    (whilo),
        .hi_o       (hi_cur),
        .lo_o       (lo_cur),
        .hi_wr_o    (hi_wr),
        .lo_wr_o    (lo_wr)
    );

    ex_result u_result (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .alusel_i   (alusel_i),
        .aluop_i    (aluop_i),
        .logic_i    (logic_res),
        .shift_i    (shift_res),
        .arith_i    (arith_res),
        .prod_lo_i  (prod[`EX_WORD_W-1:0]),
        .hi_i       (hi_cur),
        .lo_i       (lo_cur),
        .hi_wr_i    (hi_wr),
        .lo_wr_i    (lo_wr),
        .wd_i       (wd_i),
        .wreg_i     (wreg),
        .whilo_i    (whilo),
        .wd_o       (wd_o),
        .wreg_o     (wreg_o),
        .wdata_o    (wdata_o),
        .whilo_o    (whilo_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o)
    );

endmodule

/* ex_result.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_result (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ex_pkg::alusel_t     alusel_i,
    input  ex_pkg::aluop_t      aluop_i,
    input  ex_pkg::word_t       logic_i,
    input  ex_pkg::word_t       shift_i,
    input  ex_pkg::word_t       arith_i,
    input  ex_pkg::word_t       prod_lo_i,
    input  ex_pkg::word_t       hi_i,
    input  ex_pkg::word_t       lo_i,
    input  ex_pkg::word_t       hi_wr_i,
    input  ex_pkg::word_t       lo_wr_i,
    input  ex_pkg::reg_addr_t   wd_i,
    input  logic                wreg_i,
    input  logic                whilo_i,
    output ex_pkg::reg_addr_t   wd_o,
    output logic                wreg_o,
    output ex_pkg::word_t       wdata_o,
    output logic                whilo_o,
    output ex_pkg::word_t       hi_o,
    output ex_pkg::word_t       lo_o
);
    import ex_pkg::*;

    word_t move_res;
    word_t result;

    assign move_res = (aluop_i == `EX_OP_MFHI) ? hi_i :
                      (aluop_i == `EX_OP_MFLO) ? lo_i : '0;

    always_comb
    begin
        case (alusel_i)
            `EX_SEL_LOGIC: result = logic_i;
            `EX_SEL_SHIFT: result = shift_i;
            `EX_SEL_ARITH: result = arith_i;
            `EX_SEL_MUL:   result = prod_lo_i;  // mul keeps the low word
            `EX_SEL_MOVE:  result = move_res;
            default:       result = '0;
        endcase
    end

    // ex/mem style output register
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            wd_o    <= '0;
            wreg_o  <= 1'b0;
            wdata_o <= '0;
            whilo_o <= 1'b0;
            hi_o    <= '0;
            lo_o    <= '0;
        end
        else
        begin
            wd_o    <= wd_i;
            wreg_o  <= wreg_i;
            wdata_o <= result;
            whilo_o <= whilo_i;
            hi_o    <= whilo_i ? hi_wr_i : '0;
            lo_o    <= whilo_i ? lo_wr_i : '0;
        end
    end

endmodule

/* ex_hilo.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_hilo (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  ex_pkg::word_t               reg1_i,
    input  ex_pkg::dword_t              prod_i,
    input  logic [`EX_HILO_SRC_W-1:0]   hilo_src_i,
    input  logic                        stash_i,
    input  logic                        whilo_i,
    output ex_pkg::word_t               hi_o,
    output ex_pkg::word_t               lo_o,
    output ex_pkg::word_t               hi_wr_o,
    output ex_pkg::word_t               lo_wr_o
);
    import ex_pkg::*;

    dword_t hilo_q;
    dword_t hilo_d;
    dword_t stash_q;    // product held between the two macc cycles

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            hilo_q <= '0;
        end
        else if (whilo_i)
        begin
            hilo_q <= hilo_d;
        end
    end

    always_ff @(posedge clk)
    begin
        if (stash_i)
        begin
            stash_q <= prod_i;
        end
    end

    always_comb
    begin
        case (hilo_src_i)
            `EX_HILO_ACCUM: hilo_d = hilo_q + stash_q;
            `EX_HILO_MTHI:  hilo_d = {reg1_i, hilo_q[`EX_WORD_W-1:0]};
            `EX_HILO_MTLO:  hilo_d = {hilo_q[2*`EX_WORD_W-1:`EX_WORD_W], reg1_i};
            default:        hilo_d = prod_i;    // mult/multu
        endcase
    end

    // current value for mfhi/mflo
    assign hi_o = hilo_q[2*`EX_WORD_W-1:`EX_WORD_W];
    assign lo_o = hilo_q[`EX_WORD_W-1:0];

    assign hi_wr_o = hilo_d[2*`EX_WORD_W-1:`EX_WORD_W];
    assign lo_wr_o = hilo_d[`EX_WORD_W-1:0];

endmodule

/* ex_mult.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mult (
    input  ex_pkg::word_t   reg1_i,
    input  ex_pkg::word_t   reg2_i,
    input  logic            mult_signed_i,
    input  logic            prod_negate_i,
    output ex_pkg::dword_t  prod_o
);
    import ex_pkg::*;

    localparam int MSB = `EX_WORD_W - 1;

    word_t  mag1;
    word_t  mag2;
    dword_t raw;
    logic   signs_differ;
    logic   negate;

    // magnitudes only in signed mode
    assign mag1 = (mult_signed_i && reg1_i[MSB]) ? (~reg1_i + 1'b1) : reg1_i;
    assign mag2 = (mult_signed_i && reg2_i[MSB]) ? (~reg2_i + 1'b1) : reg2_i;

    assign raw = dword_t'(mag1) * dword_t'(mag2);

    assign signs_differ = mult_signed_i && (reg1_i[MSB] ^ reg2_i[MSB]);

    // msub flips the sign once more
    assign negate = signs_differ ^ prod_negate_i;

    assign prod_o = negate ? (~raw + 1'b1) : raw;

endmodule

/* ex_arith.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_arith (
    input  ex_pkg::aluop_t  aluop_i,
    input  ex_pkg::word_t   reg1_i,
    input  ex_pkg::word_t   reg2_i,
    input  logic            sub_i,
    input  logic            slt_signed_i,
    output ex_pkg::word_t   arith_o,
    output logic            ovf_o
);
    import ex_pkg::*;

    localparam int MSB = `EX_WORD_W - 1;

    word_t     opb;
    word_t     sum;
    logic      lt;
    lead_cnt_t zeros;
    lead_cnt_t ones;

    function automatic lead_cnt_t lead_zeros(input word_t w);
        lead_cnt_t cnt;
        logic      done;
        cnt  = '0;
        done = 1'b0;
        for (int i = MSB; i >= 0; i--)
        begin
            if (w[i])
            begin
                done = 1'b1;
            end
            else if (!done)
            begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    // a - b as a + ~b + 1
    assign opb = sub_i ? ~reg2_i : reg2_i;
    assign sum = reg1_i + opb + word_t'(sub_i);

    // same-sign addends, sum sign flipped
    assign ovf_o = (reg1_i[MSB] == opb[MSB]) && (sum[MSB] != reg1_i[MSB]);

    assign lt = slt_signed_i ? (sum[MSB] ^ ovf_o) : (reg1_i < reg2_i);

    assign zeros = lead_zeros(reg1_i);
    assign ones  = lead_zeros(~reg1_i);  // clo counts zeros of the complement

    always_comb
    begin
        case (aluop_i)
            `EX_OP_SLT, `EX_OP_SLTU:
                arith_o = word_t'(lt);
            `EX_OP_ADD, `EX_OP_ADDU, `EX_OP_ADDI, `EX_OP_ADDIU, `EX_OP_SUB, `EX_OP_SUBU:
                arith_o = sum;
            `EX_OP_CLZ:
                arith_o = {{(`EX_WORD_W-$bits(lead_cnt_t)){1'b0}}, zeros};
            `EX_OP_CLO:
                arith_o = {{(`EX_WORD_W-$bits(lead_cnt_t)){1'b0}}, ones};
            default:
                arith_o = '0;
        endcase
    end

endmodule

/* ex_logic_shift.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_logic_shift (
    input  ex_pkg::aluop_t  aluop_i,
    input  ex_pkg::word_t   reg1_i,
    input  ex_pkg::word_t   reg2_i,
    output ex_pkg::word_t   logic_o,
    output ex_pkg::word_t   shift_o
);
    import ex_pkg::*;

    shamt_t shamt;

    assign shamt = reg1_i[$bits(shamt_t)-1:0];  // upper bits ignored

    always_comb
    begin
        case (aluop_i)
            `EX_OP_OR:  logic_o = reg1_i | reg2_i;
            `EX_OP_AND: logic_o = reg1_i & reg2_i;
            `EX_OP_NOR: logic_o = ~(reg1_i | reg2_i);
            `EX_OP_XOR: logic_o = reg1_i ^ reg2_i;
            default:    logic_o = '0;
        endcase
    end

    always_comb
    begin
        case (aluop_i)
            `EX_OP_SLL:
            begin
                shift_o = reg2_i << shamt;
            end
            `EX_OP_SRL:
            begin
                shift_o = reg2_i >> shamt;
            end
            `EX_OP_SRA:
            begin
                shift_o = word_t'($signed(reg2_i) >>> shamt);  // sign fill
            end
            default:
            begin
                shift_o = '0;
            end
        endcase
    end

endmodule

/* ex_ctrl.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_ctrl (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  ex_pkg::aluop_t              aluop_i,
    input  logic                        wreg_i,
    input  logic                        ovf_i,
    output logic                        stall_o,
    output logic                        mult_signed_o,
    output logic                        prod_negate_o,
    output logic                        sub_o,
    output logic                        slt_signed_o,
    output logic [`EX_HILO_SRC_W-1:0]   hilo_src_o,
    output logic                        stash_o,
    output logic                        whilo_o,
    output logic                        wreg_o
);
    import ex_pkg::*;

    macc_state_e state_q;
    logic        is_macc;
    logic        ovf_trap;

    assign is_macc = (aluop_i == `EX_OP_MADD) || (aluop_i == `EX_OP_MADDU) ||
                     (aluop_i == `EX_OP_MSUB) || (aluop_i == `EX_OP_MSUBU);

    // first macc cycle stalls and stashes the product
    assign stall_o = is_macc && (state_q == MACC_IDLE);
    assign stash_o = stall_o;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            state_q <= MACC_IDLE;
        end
        else if (stall_o)
        begin
            state_q <= MACC_ACCUM;
        end
        else
        begin
            state_q <= MACC_IDLE;   // accum lasts one cycle
        end
    end

    assign mult_signed_o = (aluop_i == `EX_OP_MUL) || (aluop_i == `EX_OP_MULT) ||
                           (aluop_i == `EX_OP_MADD) || (aluop_i == `EX_OP_MSUB);
    assign prod_negate_o = (aluop_i == `EX_OP_MSUB) || (aluop_i == `EX_OP_MSUBU);

    // slt goes through the subtractor, sltu compares directly
    assign sub_o        = (aluop_i == `EX_OP_SUB) || (aluop_i == `EX_OP_SUBU) ||
                          (aluop_i == `EX_OP_SLT);
    assign slt_signed_o = (aluop_i == `EX_OP_SLT);

    // trapping forms only, the unsigned ones always write
    assign ovf_trap = ovf_i && ((aluop_i == `EX_OP_ADD) || (aluop_i == `EX_OP_ADDI) ||
                                (aluop_i == `EX_OP_SUB));
    assign wreg_o   = wreg_i && !ovf_trap && !stall_o;

    always_comb
    begin
        hilo_src_o = `EX_HILO_PROD;
        whilo_o    = 1'b0;
        case (aluop_i)
            `EX_OP_MULT, `EX_OP_MULTU:
            begin
                whilo_o = 1'b1;
            end
            `EX_OP_MADD, `EX_OP_MADDU, `EX_OP_MSUB, `EX_OP_MSUBU:
            begin
                hilo_src_o = `EX_HILO_ACCUM;
                whilo_o    = (state_q == MACC_ACCUM);   // second cycle only
            end
            `EX_OP_MTHI:
            begin
                hilo_src_o = `EX_HILO_MTHI;
                whilo_o    = 1'b1;
            end
            `EX_OP_MTLO:
            begin
                hilo_src_o = `EX_HILO_MTLO;
                whilo_o    = 1'b1;
            end
            default:
            begin
                whilo_o = 1'b0;
            end
        endcase
    end

endmodule

/* ex_pkg.sv */
`include "ex_cfg.svh"

package ex_pkg;

    // operand and result words
    typedef logic [`EX_WORD_W-1:0]      word_t;
    typedef logic [2*`EX_WORD_W-1:0]    dword_t;   // product or hi:lo pair

    typedef logic [`EX_REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`EX_ALUOP_W-1:0]     aluop_t;
    typedef logic [`EX_ALUSEL_W-1:0]    alusel_t;

    // shift amount, low bits of reg1
    typedef logic [$clog2(`EX_WORD_W)-1:0] shamt_t;

    // 0..32, needs one bit more than shamt
    typedef logic [$clog2(`EX_WORD_W):0] lead_cnt_t;

    // madd/msub phase
    typedef enum logic
    {
        MACC_IDLE,
        MACC_ACCUM
    } macc_state_e;

endpackage

/* ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

`define EX_WORD_W       32
`define EX_REG_ADDR_W   5
`define EX_ALUOP_W      8
`define EX_ALUSEL_W     3
`define EX_HILO_SRC_W   2

// aluop codes
`define EX_OP_NOP       8'b0000_0000
`define EX_OP_AND       8'b0010_0100
`define EX_OP_OR        8'b0010_0101
`define EX_OP_XOR       8'b0010_0110
`define EX_OP_NOR       8'b0010_0111
`define EX_OP_SLL       8'b0111_1100
`define EX_OP_SRL       8'b0000_0010
`define EX_OP_SRA       8'b0000_0011
`define EX_OP_ADD       8'b0010_0000
`define EX_OP_ADDU      8'b0010_0001
`define EX_OP_SUB       8'b0010_0010
`define EX_OP_SUBU      8'b0010_0011
`define EX_OP_SLT       8'b0010_1010
`define EX_OP_SLTU      8'b0010_1011
`define EX_OP_ADDI      8'b0101_0101
`define EX_OP_ADDIU     8'b0101_0110
`define EX_OP_CLZ       8'b1011_0000
`define EX_OP_CLO       8'b1011_0001
`define EX_OP_MULT      8'b0001_1000
`define EX_OP_MULTU     8'b0001_1001
`define EX_OP_MUL       8'b1010_1001
`define EX_OP_MADD      8'b1010_0110
`define EX_OP_MADDU     8'b1010_1000
`define EX_OP_MSUB      8'b1010_1010
`define EX_OP_MSUBU     8'b1010_1011
`define EX_OP_MFHI      8'b0001_0000
`define EX_OP_MTHI      8'b0001_0001
`define EX_OP_MFLO      8'b0001_0010
`define EX_OP_MTLO      8'b0001_0011

// result groups
`define EX_SEL_NOP      3'b000
`define EX_SEL_LOGIC    3'b001
`define EX_SEL_SHIFT    3'b010
`define EX_SEL_MOVE     3'b011
`define EX_SEL_ARITH    3'b100
`define EX_SEL_MUL      3'b101

// hi/lo write source
`define EX_HILO_PROD    2'd0
`define EX_HILO_ACCUM   2'd1
`define EX_HILO_MTHI    2'd2
`define EX_HILO_MTLO    2'd3

`endif
